//--- sim.f
+incdir+include
src/rob_pkg.sv
src/rob_ifs.sv
src/rename_stage.sv
src/reorder_buffer.sv
src/register_file.sv
src/rob_core_top.sv
verification/rob_core_tb.sv

//--- Makefile
BIN = obj_dir/Vrob_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rob_core_tb

run: compile
	./$(BIN) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- verification/rob_core_tb.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_core_tb;
    import rob_pkg::*;

    // six short tests of well under 300 cycles each
    localparam int MAX_CYCLES = 2000;

    logic     clk;
    logic     reset;
    logic     dispatch_valid;
    reg_idx_t dispatch_rd;
    reg_idx_t dispatch_rs1;
    reg_idx_t dispatch_rs2;
    logic     dispatch_is_io;
    logic     stall;
    logic     issue_valid;
    rob_tag_t issue_tag;
    word_t    issue_v1;
    rob_tag_t issue_q1;
    word_t    issue_v2;
    rob_tag_t issue_q2;
    logic     alu_valid;
    rob_tag_t alu_tag;
    word_t    alu_result;
    logic     alu_jump;
    addr_t    alu_target;
    logic     mem_valid;
    rob_tag_t mem_tag;
    word_t    mem_result;
    rob_tag_t store_ack_tag;
    rob_tag_t head_io_tag;
    logic     commit_valid;
    reg_idx_t commit_rd;
    rob_tag_t commit_tag;
    word_t    commit_value;
    logic     redirect_valid;
    addr_t    redirect_pc;

    // reference model indexed by tag
    int       exp_q[$];
    int       exp_rd     [`ROB_SIZE+1];
    int       exp_val    [`ROB_SIZE+1];
    logic     exp_jump   [`ROB_SIZE+1];
    int       exp_target [`ROB_SIZE+1];
    int       arch       [`REG_COUNT];
    int       next_tag;

    logic [31:0] lfsr;
    int       errors;
    int       tests_passed;
    int       tests_failed;
    int       cycles;

    rob_core_top rob_core_top_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int take_bits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic int pick_reg();
        return 1 + take_bits(5) % 31;
    endfunction

    task automatic check_value(string name, int actual, int expected);
        assert (actual == expected) else begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(string name, int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    // one dispatch attempt with issue sampled after the accepting edge
    task automatic dispatch_instr(input int rd, input int rs1, input int rs2,
                                  input logic io, output logic accepted);
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch_rd    <= reg_idx_t'(rd);
        dispatch_rs1   <= reg_idx_t'(rs1);
        dispatch_rs2   <= reg_idx_t'(rs2);
        dispatch_is_io <= io;
        @(negedge clk);
        accepted = !stall;
        @(posedge clk);
        dispatch_valid <= 1'b0;
        @(negedge clk);
        check_value("issue_valid", int'(issue_valid), int'(accepted));
        if (accepted) begin
            check_value("issue_tag", int'(issue_tag), next_tag);
            exp_rd[next_tag]     = rd;
            exp_val[next_tag]    = io ? 0 : take_bits(32);
            exp_jump[next_tag]   = 1'b0;
            exp_target[next_tag] = 0;
            exp_q.push_back(next_tag);
            next_tag = (next_tag == `ROB_SIZE) ? 1 : next_tag + 1;
        end
    endtask

    task automatic complete_instr(input int tag, input logic on_mem);
        @(posedge clk);
        if (on_mem) begin
            mem_valid  <= 1'b1;
            mem_tag    <= rob_tag_t'(tag);
            mem_result <= word_t'(exp_val[tag]);
        end else begin
            alu_valid  <= 1'b1;
            alu_tag    <= rob_tag_t'(tag);
            alu_result <= word_t'(exp_val[tag]);
            alu_jump   <= exp_jump[tag];
            alu_target <= addr_t'(exp_target[tag]);
        end
        @(posedge clk);
        alu_valid <= 1'b0;
        alu_jump  <= 1'b0;
        mem_valid <= 1'b0;
    endtask

    task automatic wait_drain(string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        check_true(exp_q.size() == 0, {what, " did not commit in time"});
        @(negedge clk);
    endtask

    // commit checker against the reference queue
    always @(negedge clk) begin
        int t;
        if (!reset && commit_valid) begin
            if (exp_q.size() == 0) begin
                check_true(1'b0, "commit seen with no instruction outstanding");
            end else begin
                t = exp_q.pop_front();
                check_value("commit_tag", int'(commit_tag), t);
                check_value("commit_rd", int'(commit_rd), exp_rd[t]);
                check_value("commit_value", int'(commit_value), exp_val[t]);
                check_value("redirect_valid", int'(redirect_valid), int'(exp_jump[t]));
                if (exp_rd[t] != 0) begin
                    arch[exp_rd[t]] = exp_val[t];
                end
                if (redirect_valid) begin
                    check_value("redirect_pc", int'(redirect_pc), exp_target[t]);
                    // younger entries are squashed
                    exp_q.delete();
                    next_tag = 1;
                end
            end
        end else if (!reset) begin
            check_true(!redirect_valid, "redirect without a commit");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int   errs;
        int   order[8];
        int   pend[$];
        int   tmp;
        int   j;
        int   ta;
        int   xval;
        int   n;
        logic acc;

        lfsr = 32'h700bb5a9;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles = 0;
        next_tag = 1;
        for (int i = 0; i < `REG_COUNT; i++) begin
            arch[i] = 0;
        end
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_rd = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_is_io = 1'b0;
        alu_valid = 1'b0;
        alu_tag = '0;
        alu_result = '0;
        alu_jump = 1'b0;
        alu_target = '0;
        mem_valid = 1'b0;
        mem_tag = '0;
        mem_result = '0;
        store_ack_tag = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // reset state
        errs = errors;
        @(negedge clk);
        check_value("commit_valid", int'(commit_valid), 0);
        check_value("redirect_valid", int'(redirect_valid), 0);
        check_value("issue_valid", int'(issue_valid), 0);
        check_value("stall", int'(stall), 0);
        check_value("issue_v1", int'(issue_v1), 0);
        check_value("issue_q1", int'(issue_q1), 0);
        check_value("issue_v2", int'(issue_v2), 0);
        check_value("issue_q2", int'(issue_q2), 0);
        end_test("reset state", errs);

        // eight instructions, completed out of order
        errs = errors;
        for (int i = 0; i < 8; i++) begin
            order[i] = next_tag;
            dispatch_instr(pick_reg(), 0, 0, 1'b0, acc);
        end
        for (int i = 7; i > 0; i--) begin
            j = take_bits(8) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++) begin
            complete_instr(order[i], take_bits(1) == 1);
        end
        wait_drain("in-order group");
        end_test("in-order commit", errs);

        // operand renaming through tags, buffer and register file
        errs = errors;
        ta = next_tag;
        dispatch_instr(5, 0, 0, 1'b0, acc);
        xval = exp_val[ta];
        dispatch_instr(6, 5, 0, 1'b0, acc);
        check_value("issue_q1", int'(issue_q1), ta);
        check_value("issue_v1", int'(issue_v1), 0);
        complete_instr(ta, 1'b0);
        dispatch_instr(7, 0, 5, 1'b0, acc);
        check_value("issue_v2", int'(issue_v2), xval);
        check_value("issue_q2", int'(issue_q2), 0);
        pend = exp_q;
        foreach (pend[i]) complete_instr(pend[i], 1'b1);
        wait_drain("renaming group");
        dispatch_instr(8, 5, 0, 1'b0, acc);
        check_value("issue_v1", int'(issue_v1), arch[5]);
        check_value("issue_q1", int'(issue_q1), 0);
        complete_instr(exp_q[0], 1'b0);
        wait_drain("register file reader");
        end_test("operand renaming", errs);

        // back-pressure at 12 occupied slots
        errs = errors;
        for (int i = 0; i < 12; i++) begin
            check_value("stall", int'(stall), 0);
            dispatch_instr(pick_reg(), 0, 0, 1'b0, acc);
        end
        check_value("stall", int'(stall), 1);
        dispatch_instr(pick_reg(), 0, 0, 1'b0, acc);
        check_true(!acc, "dispatch accepted while stalled");
        complete_instr(exp_q[0], 1'b0);
        n = 0;
        while (stall && n < 20) begin
            @(negedge clk);
            n++;
        end
        check_true(!stall, "stall stayed high after a commit");
        dispatch_instr(pick_reg(), 0, 0, 1'b0, acc);
        check_true(acc, "dispatch refused after stall dropped");
        pend = exp_q;
        foreach (pend[i]) complete_instr(pend[i], take_bits(1) == 1);
        wait_drain("stall group");
        end_test("stall", errs);

        // taken jump flushes younger entries
        errs = errors;
        ta = next_tag;
        dispatch_instr(pick_reg(), 0, 0, 1'b0, acc);
        exp_jump[ta] = 1'b1;
        exp_target[ta] = take_bits(30) << 2;
        dispatch_instr(5, 0, 0, 1'b0, acc);
        dispatch_instr(6, 0, 0, 1'b0, acc);
        complete_instr(exp_q[1], 1'b0);
        complete_instr(exp_q[2], 1'b1);
        complete_instr(ta, 1'b0);
        wait_drain("jump");
        check_value("stall", int'(stall), 0);
        dispatch_instr(11, 5, 6, 1'b0, acc);
        check_value("issue_tag", int'(issue_tag), 1);
        check_value("issue_q1", int'(issue_q1), 0);
        check_value("issue_q2", int'(issue_q2), 0);
        check_value("issue_v1", int'(issue_v1), arch[5]);
        check_value("issue_v2", int'(issue_v2), arch[6]);
        complete_instr(exp_q[0], 1'b0);
        wait_drain("post-flush reader");
        end_test("jump flush", errs);

        // I/O store waits for the acknowledge
        errs = errors;
        ta = next_tag;
        dispatch_instr(0, 0, 0, 1'b1, acc);
        check_value("head_io_tag", int'(head_io_tag), ta);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_true(!commit_valid, "store committed before its acknowledge");
        end
        @(posedge clk);
        store_ack_tag <= rob_tag_t'(ta);
        @(posedge clk);
        store_ack_tag <= '0;
        wait_drain("I/O store");
        end_test("I/O store", errs);

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/rob_core_top.sv
`timescale 1ns/1ps

module rob_core_top (
    input  logic               clk,
    input  logic               reset,

    input  logic               dispatch_valid,
    input  rob_pkg::reg_idx_t  dispatch_rd,
    input  rob_pkg::reg_idx_t  dispatch_rs1,
    input  rob_pkg::reg_idx_t  dispatch_rs2,
    input  logic               dispatch_is_io,
    output logic               stall,

    output logic               issue_valid,
    output rob_pkg::rob_tag_t  issue_tag,
    output rob_pkg::word_t     issue_v1,
    output rob_pkg::rob_tag_t  issue_q1,
    output rob_pkg::word_t     issue_v2,
    output rob_pkg::rob_tag_t  issue_q2,

    input  logic               alu_valid,
    input  rob_pkg::rob_tag_t  alu_tag,
    input  rob_pkg::word_t     alu_result,
    input  logic               alu_jump,
    input  rob_pkg::addr_t     alu_target,

    input  logic               mem_valid,
    input  rob_pkg::rob_tag_t  mem_tag,
    input  rob_pkg::word_t     mem_result,

    input  rob_pkg::rob_tag_t  store_ack_tag,
    output rob_pkg::rob_tag_t  head_io_tag,

    output logic               commit_valid,
    output rob_pkg::reg_idx_t  commit_rd,
    output rob_pkg::rob_tag_t  commit_tag,
    output rob_pkg::word_t     commit_value,

    output logic               redirect_valid,
    output rob_pkg::addr_t     redirect_pc
);
    import rob_pkg::*;

    rob_alloc_if  alloc_bus ();
    rob_query_if  query_bus ();
    rob_commit_if commit_bus ();

    reg_idx_t rf_rs1;
    reg_idx_t rf_rs2;
    word_t    rf_v1;
    word_t    rf_v2;
    rob_tag_t rf_q1;
    rob_tag_t rf_q2;
    logic     rename_en;
    reg_idx_t rename_rd;
    rob_tag_t rename_tag;

    rename_stage rename_stage_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (commit_bus.commit_jump),
        .dispatch_valid (dispatch_valid),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_is_io (dispatch_is_io),
        .rf_rs1         (rf_rs1),
        .rf_rs2         (rf_rs2),
        .rf_v1          (rf_v1),
        .rf_v2          (rf_v2),
        .rf_q1          (rf_q1),
        .rf_q2          (rf_q2),
        .rename_en      (rename_en),
        .rename_rd      (rename_rd),
        .rename_tag     (rename_tag),
        .stall          (stall),
        .issue_valid    (issue_valid),
        .issue_tag      (issue_tag),
        .issue_v1       (issue_v1),
        .issue_q1       (issue_q1),
        .issue_v2       (issue_v2),
        .issue_q2       (issue_q2),
        .alloc          (alloc_bus.requester),
        .query          (query_bus.requester)
    );

    reorder_buffer reorder_buffer_i (
        .clk           (clk),
        .reset         (reset),
        .alu_valid     (alu_valid),
        .alu_tag       (alu_tag),
        .alu_result    (alu_result),
        .alu_jump      (alu_jump),
        .alu_target    (alu_target),
        .mem_valid     (mem_valid),
        .mem_tag       (mem_tag),
        .mem_result    (mem_result),
        .store_ack_tag (store_ack_tag),
        .head_io_tag   (head_io_tag),
        .alloc         (alloc_bus.buffer),
        .query         (query_bus.buffer),
        .commit        (commit_bus.source)
    );

    register_file register_file_i (
        .clk        (clk),
        .reset      (reset),
        .rs1        (rf_rs1),
        .rs2        (rf_rs2),
        .v1         (rf_v1),
        .v2         (rf_v2),
        .q1         (rf_q1),
        .q2         (rf_q2),
        .rename_en  (rename_en),
        .rename_rd  (rename_rd),
        .rename_tag (rename_tag),
        .commit     (commit_bus.sink)
    );

    assign commit_valid = commit_bus.commit_valid;
    assign commit_rd    = commit_bus.commit_rd;
    assign commit_tag   = commit_bus.commit_tag;
    assign commit_value = commit_bus.commit_value;

    // committed taken jump redirects fetch
    assign redirect_valid = commit_bus.commit_jump;
    assign redirect_pc    = commit_bus.commit_target;

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module register_file (
    input  logic               clk,
    input  logic               reset,

    input  rob_pkg::reg_idx_t  rs1,
    input  rob_pkg::reg_idx_t  rs2,
    output rob_pkg::word_t     v1,
    output rob_pkg::word_t     v2,
    output rob_pkg::rob_tag_t  q1,
    output rob_pkg::rob_tag_t  q2,

    input  logic               rename_en,
    input  rob_pkg::reg_idx_t  rename_rd,
    input  rob_pkg::rob_tag_t  rename_tag,

    rob_commit_if.sink         commit
);
    import rob_pkg::*;

    word_t    regs [`REG_COUNT];
    // youngest in-flight producer per register
    rob_tag_t tags [`REG_COUNT];

    logic commit_write;

    assign commit_write = commit.commit_valid && (commit.commit_rd != '0);

    // x0 is hardwired
    assign v1 = (rs1 == '0) ? '0 : regs[rs1];
    assign v2 = (rs2 == '0) ? '0 : regs[rs2];
    assign q1 = (rs1 == '0) ? '0 : tags[rs1];
    assign q2 = (rs2 == '0) ? '0 : tags[rs2];

    always_ff @(posedge clk) begin
        if (commit_write) begin
            regs[commit.commit_rd] <= commit.commit_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || commit.commit_jump) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                tags[i] <= '0;
            end
        end else begin
            // a younger rename keeps its own tag
            if (commit_write && (tags[commit.commit_rd] == commit.commit_tag)) begin
                tags[commit.commit_rd] <= '0;
            end
            // later assignment wins over the clear above
            if (rename_en && (rename_rd != '0)) begin
                tags[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/1ps
`include "rob_consts.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               reset,

    // ALU and branch completion
    input  logic               alu_valid,
    input  rob_pkg::rob_tag_t  alu_tag,
    input  rob_pkg::word_t     alu_result,
    input  logic               alu_jump,
    input  rob_pkg::addr_t     alu_target,

    // load completion
    input  logic               mem_valid,
    input  rob_pkg::rob_tag_t  mem_tag,
    input  rob_pkg::word_t     mem_result,

    input  rob_pkg::rob_tag_t  store_ack_tag,
    output rob_pkg::rob_tag_t  head_io_tag,

    rob_alloc_if.buffer        alloc,
    rob_query_if.buffer        query,
    rob_commit_if.source       commit
);
    import rob_pkg::*;

    localparam int IDX_W = $clog2(`ROB_SIZE);

    typedef logic [IDX_W-1:0] idx_t;

    // head == tail with count 0 means empty
    idx_t                 head;
    idx_t                 tail;
    logic [IDX_W:0]       count;

    logic [`ROB_SIZE-1:0] busy;
    logic [`ROB_SIZE-1:0] ready;
    logic [`ROB_SIZE-1:0] jump;
    logic [`ROB_SIZE-1:0] is_io;
    reg_idx_t             slot_rd     [`ROB_SIZE];
    word_t                slot_data   [`ROB_SIZE];
    addr_t                slot_target [`ROB_SIZE];

    logic do_commit;
    logic alu_hit;
    logic mem_hit;
    logic ack_hit;
    idx_t alu_idx;
    idx_t mem_idx;
    idx_t ack_idx;
    idx_t q1_idx;
    idx_t q2_idx;

    function automatic idx_t slot_of(rob_tag_t tag);
        return idx_t'(tag - rob_tag_t'(1));
    endfunction

    assign alu_idx = slot_of(alu_tag);
    assign mem_idx = slot_of(mem_tag);
    assign ack_idx = slot_of(store_ack_tag);
    assign q1_idx  = slot_of(query.q1_tag);
    assign q2_idx  = slot_of(query.q2_tag);

    // late or stale results for free slots are dropped
    assign alu_hit = alu_valid && (alu_tag != '0) && busy[alu_idx];
    assign mem_hit = mem_valid && (mem_tag != '0) && busy[mem_idx];
    assign ack_hit = (store_ack_tag != '0) && busy[ack_idx];

    assign do_commit = busy[head] && ready[head];

    assign alloc.alloc_tag = rob_tag_t'(tail) + rob_tag_t'(1);
    assign alloc.full      = count >= (`ROB_SIZE - `ROB_FULL_MARGIN);

    assign head_io_tag = (busy[head] && is_io[head]) ? rob_tag_t'(head) + rob_tag_t'(1) : '0;

    // ready stays set after commit until the slot is reused,
    // so a register tag not yet cleared still finds its value
    assign query.q1_ready = (query.q1_tag != '0) && ready[q1_idx];
    assign query.q2_ready = (query.q2_tag != '0) && ready[q2_idx];
    assign query.q1_data  = (query.q1_tag != '0) ? slot_data[q1_idx] : '0;
    assign query.q2_data  = (query.q2_tag != '0) ? slot_data[q2_idx] : '0;

    always_ff @(posedge clk) begin
        if (reset || commit.commit_jump) begin
            head                <= '0;
            tail                <= '0;
            count               <= '0;
            busy                <= '0;
            ready               <= '0;
            jump                <= '0;
            commit.commit_valid <= 1'b0;
            commit.commit_jump  <= 1'b0;
        end else begin
            commit.commit_valid <= do_commit;
            commit.commit_jump  <= do_commit && jump[head];
            if (do_commit) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end

            if (alu_hit) begin
                ready[alu_idx] <= 1'b1;
                jump[alu_idx]  <= alu_jump;
            end
            if (mem_hit) begin
                ready[mem_idx] <= 1'b1;
            end
            // store leaves the buffer once the memory side accepts it
            if (ack_hit) begin
                ready[ack_idx] <= 1'b1;
            end

            if (alloc.alloc_valid) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                jump[tail]  <= 1'b0;
                tail        <= tail + 1'b1;
            end

            case ({alloc.alloc_valid, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // slot payload and commit data
    always_ff @(posedge clk) begin
        if (do_commit) begin
            commit.commit_rd     <= slot_rd[head];
            commit.commit_tag    <= rob_tag_t'(head) + rob_tag_t'(1);
            commit.commit_value  <= slot_data[head];
            commit.commit_target <= slot_target[head];
        end
        if (alu_hit) begin
            slot_data[alu_idx]   <= alu_result;
            slot_target[alu_idx] <= alu_target;
        end
        if (mem_hit) begin
            slot_data[mem_idx] <= mem_result;
        end
        if (alloc.alloc_valid) begin
            slot_rd[tail]     <= alloc.alloc_rd;
            is_io[tail]       <= alloc.alloc_is_io;
            slot_data[tail]   <= '0;
            slot_target[tail] <= '0;
        end
    end

endmodule

//--- src/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,

    input  logic               dispatch_valid,
    input  rob_pkg::reg_idx_t  dispatch_rd,
    input  rob_pkg::reg_idx_t  dispatch_rs1,
    input  rob_pkg::reg_idx_t  dispatch_rs2,
    input  logic               dispatch_is_io,

    // register file read side
    output rob_pkg::reg_idx_t  rf_rs1,
    output rob_pkg::reg_idx_t  rf_rs2,
    input  rob_pkg::word_t     rf_v1,
    input  rob_pkg::word_t     rf_v2,
    input  rob_pkg::rob_tag_t  rf_q1,
    input  rob_pkg::rob_tag_t  rf_q2,

    // register file rename write
    output logic               rename_en,
    output rob_pkg::reg_idx_t  rename_rd,
    output rob_pkg::rob_tag_t  rename_tag,

    output logic               stall,
    output logic               issue_valid,
    output rob_pkg::rob_tag_t  issue_tag,
    output rob_pkg::word_t     issue_v1,
    output rob_pkg::rob_tag_t  issue_q1,
    output rob_pkg::word_t     issue_v2,
    output rob_pkg::rob_tag_t  issue_q2,

    rob_alloc_if.requester     alloc,
    rob_query_if.requester     query
);
    import rob_pkg::*;

    logic     accept;
    word_t    op_v1;
    word_t    op_v2;
    rob_tag_t op_q1;
    rob_tag_t op_q2;

    assign accept = dispatch_valid && !alloc.full && !flush;
    assign stall  = alloc.full;

    assign rf_rs1 = dispatch_rs1;
    assign rf_rs2 = dispatch_rs2;

    assign alloc.alloc_valid = accept;
    assign alloc.alloc_rd    = dispatch_rd;
    assign alloc.alloc_is_io = dispatch_is_io;

    // only pending operands need the buffer
    assign query.q1_tag = rf_q1;
    assign query.q2_tag = rf_q2;

    // x0 keeps no producer
    assign rename_en  = accept && (dispatch_rd != '0);
    assign rename_rd  = dispatch_rd;
    assign rename_tag = alloc.alloc_tag;

    always_comb begin
        op_v1 = rf_v1;
        op_q1 = '0;
        if (rf_q1 != '0) begin
            // producer done but not yet retired
            op_v1 = query.q1_ready ? query.q1_data : '0;
            op_q1 = query.q1_ready ? '0 : rf_q1;
        end
        op_v2 = rf_v2;
        op_q2 = '0;
        if (rf_q2 != '0) begin
            op_v2 = query.q2_ready ? query.q2_data : '0;
            op_q2 = query.q2_ready ? '0 : rf_q2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue_valid <= 1'b0;
            issue_tag   <= '0;
            issue_v1    <= '0;
            issue_q1    <= '0;
            issue_v2    <= '0;
            issue_q2    <= '0;
        end else begin
            issue_valid <= accept;
            if (accept) begin
                issue_tag <= alloc.alloc_tag;
                issue_v1  <= op_v1;
                issue_q1  <= op_q1;
                issue_v2  <= op_v2;
                issue_q2  <= op_q2;
            end
        end
    end

endmodule

//--- src/rob_ifs.sv
`timescale 1ns/1ps

// slot allocation, rename stage to reorder buffer
interface rob_alloc_if;
    import rob_pkg::*;

    logic     alloc_valid;
    reg_idx_t alloc_rd;
    logic     alloc_is_io;
    rob_tag_t alloc_tag;
    logic     full;

    modport requester (output alloc_valid, alloc_rd, alloc_is_io, input alloc_tag, full);
    modport buffer (input alloc_valid, alloc_rd, alloc_is_io, output alloc_tag, full);
endinterface

// operand lookup of pending tags, answered combinationally
interface rob_query_if;
    import rob_pkg::*;

    rob_tag_t q1_tag;
    rob_tag_t q2_tag;
    logic     q1_ready;
    logic     q2_ready;
    word_t    q1_data;
    word_t    q2_data;

    modport requester (output q1_tag, q2_tag, input q1_ready, q2_ready, q1_data, q2_data);
    modport buffer (input q1_tag, q2_tag, output q1_ready, q2_ready, q1_data, q2_data);
endinterface

// retirement of the head slot
interface rob_commit_if;
    import rob_pkg::*;

    logic     commit_valid;
    reg_idx_t commit_rd;
    rob_tag_t commit_tag;
    word_t    commit_value;
    // taken jump, doubles as the flush
    logic     commit_jump;
    addr_t    commit_target;

    modport source (output commit_valid, commit_rd, commit_tag, commit_value,
                    commit_jump, commit_target);
    modport sink (input commit_valid, commit_rd, commit_tag, commit_value,
                  commit_jump, commit_target);
endinterface

//--- src/rob_pkg.sv
`include "rob_consts.svh"

package rob_pkg;

    // reorder buffer tag, 0 = value already known
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // architectural register number
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // result and operand value
    typedef logic [`XLEN-1:0] word_t;

    // program counter
    typedef logic [`XLEN-1:0] addr_t;

endpackage

//--- include/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// reorder buffer slots, power of two
`define ROB_SIZE 16
// slot index plus one, zero means no producer
`define ROB_TAG_W 5

`define REG_COUNT 32
`define REG_IDX_W 5
`define XLEN 32

// headroom for instructions already in flight upstream
`define ROB_FULL_MARGIN 4

`endif
